// File: Makefile
TOP = tb_threshold_cutter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir

# the binary keeps running past assertion errors so the testbench can report them
run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: axis_square.sv
`default_nettype none
`timescale 1ns/1ps

`include "threshold_cutter_cfg.svh"

module axis_square
	import energy_types_pkg::*;
(
	input  wire logic clk_50m,
	input  wire logic sys_rst_n,
	input  wire logic start_i,
	input  wire axis_t value_i,
	output logic done_o,
	output square_t square_o
);

	localparam int CNT_W = $clog2(`SQUARE_CYCLES);

	typedef enum logic {idle, busy} sq_state_e;

	sq_state_e state;
	logic [CNT_W - 1:0] step;
	square_t mcand;
	axis_t mplier;

	// step counts finished multiplier bits
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			state <= idle;
			step <= '0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			case (state)
				idle:
				begin
					if (start_i)
					begin
						state <= busy;
						step <= CNT_W'(1);
					end
				end
				busy:
				begin
					step <= step + 1'b1;
					if (step == CNT_W'(`SQUARE_CYCLES - 1))
					begin
						done_o <= 1'b1;
						state <= idle;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	// first partial product is taken with the operand itself
	always_ff @(posedge clk_50m)
	begin
		if ((state == idle) && start_i)
		begin
			square_o <= value_i[0] ? square_t'(value_i) : '0;
			mcand <= square_t'(value_i) << 1;
			mplier <= value_i >> 1;
		end
		else if (state == busy)
		begin
			if (mplier[0])
				square_o <= square_o + mcand;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

`default_nettype wire

// File: energy_judge.sv
`default_nettype none
`timescale 1ns/1ps

`include "threshold_cutter_cfg.svh"

module energy_judge
	import energy_types_pkg::*;
(
	input  wire logic clk_50m,
	input  wire logic sys_rst_n,
	input  wire logic start_i,
	input  wire record_t record_i,
	input  wire logic [2:0] done_i,
	input  wire square_t [2:0] square_i,
	output logic slot_free_o,
	output logic out_req_o,
	output record_t out_record_o,
	output logic out_flag_o,
	input  wire logic out_ack_i
);

	typedef enum logic [1:0] {empty, computing, req_high, wait_ack_low} judge_state_e;

	judge_state_e state;
	energy_t energy;
	logic all_done;

	// widen before adding so no carry is lost
	assign energy = energy_t'(square_i[0]) + energy_t'(square_i[1]) + energy_t'(square_i[2]);
	assign all_done = &done_i;

	assign slot_free_o = (state == empty);
	assign out_req_o = (state == req_high);

	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
			state <= empty;
		else
		begin
			case (state)
				empty:
				begin
					if (start_i)
						state <= computing;
				end
				computing:
				begin
					if (all_done)
						state <= req_high;
				end
				req_high:
				begin
					if (out_ack_i)
						state <= wait_ack_low;
				end
				wait_ack_low:
				begin
					if (!out_ack_i)
						state <= empty;
				end
				default:
					state <= empty;
			endcase
		end
	end

	// result only changes while no handout is pending
	always_ff @(posedge clk_50m)
	begin
		if ((state == empty) && start_i)
			out_record_o <= record_i;
		if ((state == computing) && all_done)
			out_flag_o <= (energy >= energy_t'(`ENERGY_THRESHOLD));
	end

endmodule

`default_nettype wire

// File: energy_types_pkg.sv
`default_nettype none

`include "threshold_cutter_cfg.svh"

package energy_types_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`AXIS_WIDTH - 1:0] axis_t;
	typedef logic [2 * `AXIS_WIDTH - 1:0] square_t;
	// two extra bits so three squares never wrap
	typedef logic [2 * `AXIS_WIDTH + 1:0] energy_t;
	// all payload bytes of one frame
	typedef logic [`PACKAGE_NUM * `PAYLOAD_BYTES * 8 - 1:0] record_t;

endpackage

`default_nettype wire

// File: filelist.f
+incdir+.
frame_fmt_pkg.sv
energy_types_pkg.sv
frame_parser.sv
axis_square.sv
energy_judge.sv
threshold_cutter_top.sv
threshold_cutter_sva.sv
tb_threshold_cutter.sv

// File: frame_fmt_pkg.sv
`default_nettype none

`include "threshold_cutter_cfg.svh"

package frame_fmt_pkg;

	typedef logic [$clog2(`PACKAGE_SIZE) - 1:0] byte_pos_t;
	typedef logic [$clog2(`PACKAGE_NUM) - 1:0] pkg_idx_t;

	// what a byte position inside a package holds
	typedef enum logic [1:0] {HEADER, FUNCTION, PAYLOAD, CHECKSUM} field_kind_e;

endpackage

`default_nettype wire

// File: frame_parser.sv
`default_nettype none
`timescale 1ns/1ps

`include "threshold_cutter_cfg.svh"

module frame_parser
	import frame_fmt_pkg::*, energy_types_pkg::*;
(
	input  wire logic clk_50m,
	input  wire logic sys_rst_n,
	input  wire logic in_req_i,
	input  wire byte_t in_data_i,
	output logic in_ack_o,
	input  wire logic slot_free_i,
	output logic start_o,
	output axis_t [2:0] axis_o,
	output record_t record_o
);

	// Ax, Ay and Az bytes in package 0
	localparam int AXIS_BYTES = 3 * (`AXIS_WIDTH / 8);

	typedef enum logic [1:0] {idle, wait_req_low, hold_last} parse_state_e;

	parse_state_e state;
	byte_pos_t byte_pos;
	pkg_idx_t pkg_idx;
	field_kind_e kind;
	byte_pos_t a_rel;
	logic capture;
	logic last_byte;
	logic in_axis;

	// classify the current byte position
	always_comb
	begin
		kind = PAYLOAD;
		if (byte_pos == '0)
			kind = HEADER;
		else if (byte_pos < byte_pos_t'(`PAYLOAD_FIRST))
			kind = FUNCTION;
		else if (byte_pos >= byte_pos_t'(`PAYLOAD_FIRST + `PAYLOAD_BYTES))
			kind = CHECKSUM;
	end

	assign capture = (state == idle) && in_req_i;
	assign last_byte = (kind == CHECKSUM) && (pkg_idx == pkg_idx_t'(`PACKAGE_NUM - 1));
	assign a_rel = byte_pos - byte_pos_t'(`A_OFFSET);
	assign in_axis = (pkg_idx == '0) && (byte_pos >= byte_pos_t'(`A_OFFSET)) &&
		(a_rel < byte_pos_t'(AXIS_BYTES));

	// handshake and byte counting
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			state <= idle;
			in_ack_o <= 1'b0;
			start_o <= 1'b0;
			byte_pos <= '0;
			pkg_idx <= '0;
		end
		else
		begin
			start_o <= 1'b0;
			case (state)
				idle:
				begin
					if (in_req_i)
					begin
						if (byte_pos == byte_pos_t'(`PACKAGE_SIZE - 1))
						begin
							byte_pos <= '0;
							if (pkg_idx == pkg_idx_t'(`PACKAGE_NUM - 1))
								pkg_idx <= '0;
							else
								pkg_idx <= pkg_idx + 1'b1;
						end
						else
							byte_pos <= byte_pos + 1'b1;
						// last checksum waits for a free result slot before its ack
						if (last_byte)
							state <= hold_last;
						else
						begin
							in_ack_o <= 1'b1;
							state <= wait_req_low;
						end
					end
				end
				hold_last:
				begin
					if (slot_free_i)
					begin
						start_o <= 1'b1;
						in_ack_o <= 1'b1;
						state <= wait_req_low;
					end
				end
				wait_req_low:
				begin
					if (!in_req_i)
					begin
						in_ack_o <= 1'b0;
						state <= idle;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	// payload shifts in from the bottom so the first byte ends up on top
	always_ff @(posedge clk_50m)
	begin
		if (capture)
		begin
			if (kind == PAYLOAD)
				record_o <= {record_o[$bits(record_t) - 9:0], in_data_i};
			if (in_axis)
			begin
				// little endian words
				if (a_rel[0])
					axis_o[a_rel[2:1]][15:8] <= in_data_i;
				else
					axis_o[a_rel[2:1]][7:0] <= in_data_i;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_threshold_cutter.sv
`default_nettype none
`timescale 1ns/1ps

`include "threshold_cutter_cfg.svh"

module tb_threshold_cutter
	import frame_fmt_pkg::*, energy_types_pkg::*;
();

	localparam int FRAME_BYTES = `PACKAGE_SIZE * `PACKAGE_NUM;
	localparam int RAND_FRAMES = 4;
	localparam int EDGE_FRAMES = 3;
	localparam int BP_FRAMES = 3;
	localparam int SHORT_ACK = 2;
	localparam int LONG_ACK = 200;
	localparam int ACK_TOTAL = (RAND_FRAMES + EDGE_FRAMES) * SHORT_ACK + BP_FRAMES * LONG_ACK;
	localparam int CYCLE_LIMIT = (RAND_FRAMES + EDGE_FRAMES + BP_FRAMES) *
		(FRAME_BYTES * 4 + 40) + ACK_TOTAL + 100;

	logic clk_50m;
	logic sys_rst_n;
	logic in_req_i;
	byte_t in_data_i;
	logic in_ack_o;
	logic out_req_o;
	record_t out_record_o;
	logic out_flag_o;
	logic out_ack_i;

	integer seed;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int results = 0;
	int ack_delay;
	byte_t frame_buf [FRAME_BYTES];
	record_t exp_record_q [$];
	logic exp_flag_q [$];

	threshold_cutter_top dut (
		.clk_50m      (clk_50m),
		.sys_rst_n    (sys_rst_n),
		.in_req_i     (in_req_i),
		.in_data_i    (in_data_i),
		.in_ack_o     (in_ack_o),
		.out_req_o    (out_req_o),
		.out_record_o (out_record_o),
		.out_flag_o   (out_flag_o),
		.out_ack_i    (out_ack_i)
	);

	initial
	begin
		clk_50m = 1'b0;
		forever
			#10 clk_50m = ~clk_50m;
	end

	// run limit from frame count and ack delays
	always @(posedge clk_50m)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: results still missing after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// byte position within a package, per the sensor layout
	function automatic field_kind_e kind_of(input int pos);
		if (pos == 0)
			return HEADER;
		if (pos == 1)
			return FUNCTION;
		if (pos == `PACKAGE_SIZE - 1)
			return CHECKSUM;
		return PAYLOAD;
	endfunction

	task automatic fill_frame(input bit set_axes, input axis_t ax, input axis_t ay,
		input axis_t az);
		for (int i = 0; i < FRAME_BYTES; i++)
			frame_buf[i] = byte_t'($random(seed));
		if (set_axes)
		begin
			frame_buf[`A_OFFSET] = ax[7:0];
			frame_buf[`A_OFFSET + 1] = ax[15:8];
			frame_buf[`A_OFFSET + 2] = ay[7:0];
			frame_buf[`A_OFFSET + 3] = ay[15:8];
			frame_buf[`A_OFFSET + 4] = az[7:0];
			frame_buf[`A_OFFSET + 5] = az[15:8];
		end
	endtask

	// reference model: payload n lands n bytes below the record top
	task automatic expect_frame();
		record_t rec;
		axis_t ax;
		axis_t ay;
		axis_t az;
		energy_t energy;
		int n;
		rec = '0;
		n = 0;
		for (int i = 0; i < FRAME_BYTES; i++)
		begin
			if (kind_of(i % `PACKAGE_SIZE) == PAYLOAD)
			begin
				rec[$bits(record_t) - 1 - 8 * n -: 8] = frame_buf[i];
				n++;
			end
		end
		ax = {frame_buf[`A_OFFSET + 1], frame_buf[`A_OFFSET]};
		ay = {frame_buf[`A_OFFSET + 3], frame_buf[`A_OFFSET + 2]};
		az = {frame_buf[`A_OFFSET + 5], frame_buf[`A_OFFSET + 4]};
		energy = energy_t'(ax) * energy_t'(ax) + energy_t'(ay) * energy_t'(ay) +
			energy_t'(az) * energy_t'(az);
		exp_record_q.push_back(rec);
		exp_flag_q.push_back(energy >= energy_t'(`ENERGY_THRESHOLD));
	endtask

	// one four-phase transfer
	task automatic send_byte(input byte_t value);
		@(negedge clk_50m);
		in_data_i = value;
		in_req_i = 1'b1;
		@(negedge clk_50m);
		while (!in_ack_o)
			@(negedge clk_50m);
		in_req_i = 1'b0;
		@(negedge clk_50m);
		while (in_ack_o)
			@(negedge clk_50m);
	endtask

	task automatic send_frame();
		for (int i = 0; i < FRAME_BYTES; i++)
			send_byte(frame_buf[i]);
	endtask

	task automatic drain_results();
		while (exp_record_q.size() != 0 || out_req_o || out_ack_i)
			@(negedge clk_50m);
	endtask

	task automatic print_result(input string name, input int errors_before);
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: failed with %0d errors", name, errors - errors_before);
	endtask

	// sink: compare at each new request, then ack after ack_delay cycles
	initial
	begin
		record_t exp_rec;
		logic exp_flag;
		forever
		begin
			@(negedge clk_50m);
			if (out_req_o && !out_ack_i)
			begin
				results++;
				if (exp_record_q.size() == 0)
				begin
					$display("unexpected result at %0t with no frame outstanding", $time);
					errors++;
				end
				else
				begin
					exp_rec = exp_record_q.pop_front();
					exp_flag = exp_flag_q.pop_front();
					checks += 2;
					assert (out_record_o == exp_rec)
					else
					begin
						$display("Error at %0t: record %h, expected %h", $time, out_record_o,
							exp_rec);
						errors++;
					end
					assert (out_flag_o == exp_flag)
					else
					begin
						$display("Error at %0t: flag %b, expected %b", $time, out_flag_o, exp_flag);
						errors++;
					end
				end
				repeat (ack_delay)
					@(negedge clk_50m);
				out_ack_i = 1'b1;
				while (out_req_o)
					@(negedge clk_50m);
				out_ack_i = 1'b0;
			end
		end
	end

	initial
	begin
		int errors_before;
		seed = 32'h075f_5156;
		sys_rst_n = 1'b0;
		in_req_i = 1'b0;
		in_data_i = '0;
		out_ack_i = 1'b0;
		ack_delay = SHORT_ACK;
		repeat (2)
			@(posedge clk_50m);
		@(negedge clk_50m);
		sys_rst_n = 1'b1;

		errors_before = errors;
		@(negedge clk_50m);
		checks++;
		assert (!in_ack_o && !out_req_o)
		else
		begin
			$display("Error at %0t: in_ack_o or out_req_o high after reset", $time);
			errors++;
		end
		print_result("reset state", errors_before);

		errors_before = errors;
		for (int f = 0; f < RAND_FRAMES; f++)
		begin
			fill_frame(1'b0, '0, '0, '0);
			expect_frame();
			send_frame();
		end
		drain_results();
		print_result("random frames", errors_before);

		// exactly at, just below, and far above the threshold
		errors_before = errors;
		fill_frame(1'b1, 16'd1024, 16'd0, 16'd0);
		expect_frame();
		send_frame();
		fill_frame(1'b1, 16'd1023, 16'd0, 16'd0);
		expect_frame();
		send_frame();
		fill_frame(1'b1, 16'hffff, 16'hffff, 16'hffff);
		expect_frame();
		send_frame();
		drain_results();
		print_result("flag boundaries", errors_before);

		errors_before = errors;
		ack_delay = LONG_ACK;
		for (int f = 0; f < BP_FRAMES; f++)
		begin
			fill_frame(1'b0, '0, '0, '0);
			expect_frame();
			send_frame();
		end
		drain_results();
		ack_delay = SHORT_ACK;
		print_result("output back-pressure", errors_before);

		// bound assertion failures count as errors too
		errors = errors + dut.u_sva.fail_count;
		$display("summary: %0d results, %0d checks, %0d errors", results, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: threshold_cutter_cfg.svh
`ifndef THRESHOLD_CUTTER_CFG_SVH
`define THRESHOLD_CUTTER_CFG_SVH

// frame layout of the sensor link
`define PACKAGE_SIZE 11
`define PACKAGE_NUM 4

// payload window inside one package
`define PAYLOAD_FIRST 2
`define PAYLOAD_BYTES 8

// Ax low byte in package 0
`define A_OFFSET 2

// acceleration word width
`define AXIS_WIDTH 16

// energy compare level on the sum of squares
`define ENERGY_THRESHOLD 32'h0010_0000

// one multiplier bit per clock
`define SQUARE_CYCLES 16

`endif

// File: threshold_cutter_sva.sv
`default_nettype none
`timescale 1ns/1ps

`include "threshold_cutter_cfg.svh"

module threshold_cutter_sva
	import energy_types_pkg::*;
(
	input  wire logic clk_50m,
	input  wire logic sys_rst_n,
	input  wire logic in_req_i,
	input  wire logic in_ack_o,
	input  wire logic out_req_o,
	input  wire record_t out_record_o,
	input  wire logic out_flag_o,
	input  wire logic out_ack_i
);

	localparam int FRAME_BYTES = `PACKAGE_SIZE * `PACKAGE_NUM;

	// byte acks so far, stops counting at one frame
	logic [5:0] acks_seen;
	logic ack_q;
	int fail_count = 0;

	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			acks_seen <= '0;
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= in_ack_o;
			if (in_ack_o && !ack_q && (acks_seen != 6'(FRAME_BYTES)))
				acks_seen <= acks_seen + 1'b1;
		end
	end

	a_reset_idle: assert property (@(posedge clk_50m) !sys_rst_n |=> !in_ack_o && !out_req_o)
	else
	begin
		$error("in_ack_o or out_req_o high right after reset");
		fail_count++;
	end

	a_no_early_req: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		out_req_o |-> acks_seen == 6'(FRAME_BYTES))
	else
	begin
		$error("out_req_o rose before a full frame was received");
		fail_count++;
	end

	a_ack_rise: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		$rose(in_ack_o) |-> $past(in_req_i))
	else
	begin
		$error("in_ack_o rose while in_req_i was low");
		fail_count++;
	end

	a_ack_fall: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		$fell(in_ack_o) |-> $past(!in_req_i))
	else
	begin
		$error("in_ack_o fell before in_req_i went low");
		fail_count++;
	end

	a_out_stable: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		out_req_o && !out_ack_i |=> $stable(out_record_o) && $stable(out_flag_o))
	else
	begin
		$error("record or flag changed while waiting for out_ack_i");
		fail_count++;
	end

	a_req_fall: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		$fell(out_req_o) |-> $past(out_ack_i))
	else
	begin
		$error("out_req_o fell without out_ack_i");
		fail_count++;
	end

endmodule

bind threshold_cutter_top threshold_cutter_sva u_sva (.*);

`default_nettype wire

// File: threshold_cutter_top.sv
`default_nettype none
`timescale 1ns/1ps

module threshold_cutter_top
	import energy_types_pkg::*;
(
	input  wire logic clk_50m,
	input  wire logic sys_rst_n,
	input  wire logic in_req_i,
	input  wire byte_t in_data_i,
	output logic in_ack_o,
	output logic out_req_o,
	output record_t out_record_o,
	output logic out_flag_o,
	input  wire logic out_ack_i
);

	logic start;
	logic slot_free;
	axis_t [2:0] axis;
	record_t record;
	logic [2:0] done;
	square_t [2:0] square;

	frame_parser u_parser (
		.clk_50m     (clk_50m),
		.sys_rst_n   (sys_rst_n),
		.in_req_i    (in_req_i),
		.in_data_i   (in_data_i),
		.in_ack_o    (in_ack_o),
		.slot_free_i (slot_free),
		.start_o     (start),
		.axis_o      (axis),
		.record_o    (record)
	);

	// index 0 is Ax, 1 is Ay, 2 is Az
	genvar k;
	generate
		for (k = 0; k < 3; k++)
		begin : g_axis
			axis_square u_square (
				.clk_50m   (clk_50m),
				.sys_rst_n (sys_rst_n),
				.start_i   (start),
				.value_i   (axis[k]),
				.done_o    (done[k]),
				.square_o  (square[k])
			);
		end
	endgenerate

	energy_judge u_judge (
		.clk_50m      (clk_50m),
		.sys_rst_n    (sys_rst_n),
		.start_i      (start),
		.record_i     (record),
		.done_i       (done),
		.square_i     (square),
		.slot_free_o  (slot_free),
		.out_req_o    (out_req_o),
		.out_record_o (out_record_o),
		.out_flag_o   (out_flag_o),
		.out_ack_i    (out_ack_i)
	);

endmodule

`default_nettype wire
